//--- include/mem_macros.svh
//////////////////////////////////////////////////
// Sizes of the shared memory subsystem
// Include wherever the RAM geometry is needed
//////////////////////////////////////////////////

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Word address width, 1024 words
`define MEM_ADDR_W 10

// Byte lanes per data word
`define MEM_NUM_COL 4

// Bits per byte lane
`define MEM_COL_W 8

`endif

//--- mem_subsys.f
+incdir+include
source/mem_pkg.sv
source/sp_ram.sv
source/sp_ram_be.sv
source/wb_arbiter.sv
source/wb_ram_slave.sv
source/mem_subsys.sv
sim/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the shared memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_mem_subsys \
   -f mem_subsys.f

# Keep the output even when the run stops on an error
out=$(./obj_dir/Vtb_mem_subsys 2>&1) || true
echo "$out"

if echo "$out" | grep -q "PASS: all tests"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

//--- sim/tb_mem_subsys.sv
//////////////////////////////////////////////////
// Testbench for the two-port shared memory
// Runs a table of port operations against a shadow memory
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module tb_mem_subsys;

   import mem_pkg::*;

   localparam int PERIOD  = 4;
   localparam int N_FIXED = 10;
   localparam int N_RAND  = 40;
   localparam int N_ENTRY = N_FIXED + N_RAND;
   localparam int DEPTH   = 1 << `MEM_ADDR_W;

   // One port operation in the stimulus table
   typedef struct packed {
      logic  valid;
      logic  we;
      addr_t addr;
      sel_t  sel;
      word_t data;
   } op_t;

   logic    clk;
   logic    rst_n;
   wb_req_t a_req;
   wb_req_t b_req;
   wb_rsp_t a_rsp;
   wb_rsp_t b_rsp;

   op_t   a_ops[$];             // Entry i is a_ops[i] with b_ops[i]
   op_t   b_ops[$];
   word_t shadow [0:DEPTH-1];   // Expected RAM contents
   bit    gen_written [0:DEPTH-1];
   bit    last_b;               // Port b granted most recently

   mem_subsys dut_i (
      .clk   (clk),
      .rst_n (rst_n),
      .a_req (a_req),
      .b_req (b_req),
      .a_rsp (a_rsp),
      .b_rsp (b_rsp)
   );

   always #(PERIOD/2) clk = ~clk;

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(string name, word_t got, word_t exp);
      assert (got === exp) else begin
         $display("error: t=%0t %s = %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_ack(string name, logic got, logic exp);
      assert (got === exp) else begin
         $display("error: t=%0t %s = %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   function automatic op_t make_op(logic we, addr_t addr, sel_t sel, word_t data);
      op_t op;
      op.valid = 1'b1;
      op.we    = we;
      op.addr  = addr;
      op.sel   = sel;
      op.data  = data;
      return op;
   endfunction

   // Reads only go to words that already hold known data
   function automatic op_t random_op();
      op_t   op;
      addr_t addr;
      addr     = addr_t'($urandom % 32);
      op.valid = ($urandom % 4) != 0;
      op.addr  = addr;
      op.data  = $urandom;
      if (gen_written[addr]) begin
         op.we  = ($urandom % 2) == 1;
         op.sel = sel_t'($urandom % 15 + 1);   // Never empty
      end else begin
         op.we  = 1'b1;   // First touch writes all lanes
         op.sel = '1;
      end
      return op;
   endfunction

   function automatic wb_req_t to_req(op_t op);
      wb_req_t req;
      req = '0;
      if (op.valid) begin
         req.cyc = 1'b1;
         req.stb = 1'b1;
         req.we  = op.we;
         req.adr = op.addr;
         req.sel = op.sel;
         req.dat = op.data;
      end
      return req;
   endfunction

   task automatic add_entry(op_t a_op, op_t b_op);
      a_ops.push_back(a_op);
      b_ops.push_back(b_op);
      if (a_op.valid && a_op.we) begin
         gen_written[a_op.addr] = 1'b1;
      end
      if (b_op.valid && b_op.we) begin
         gen_written[b_op.addr] = 1'b1;
      end
   endtask

   task automatic build_table();
      op_t idle;
      idle = '0;
      add_entry(make_op(1'b1, 10'h010, 4'hF, 32'hDEADBEEF),
                make_op(1'b1, 10'h020, 4'hF, 32'h12345678));   // Contended and a wins
      add_entry(make_op(1'b0, 10'h010, 4'hF, '0), idle);
      add_entry(idle, make_op(1'b1, 10'h020, 4'h1, 32'h000000AA));
      add_entry(idle, make_op(1'b1, 10'h020, 4'h6, 32'h00BBCC00));
      add_entry(make_op(1'b0, 10'h020, 4'hF, '0), idle);
      add_entry(make_op(1'b1, 10'h010, 4'h8, 32'h11000000),
                make_op(1'b0, 10'h020, 4'hF, '0));             // Contended and b wins
      add_entry(make_op(1'b0, 10'h010, 4'hF, '0),
                make_op(1'b0, 10'h010, 4'hF, '0));
      add_entry(make_op(1'b1, 10'h040, 4'hF, 32'h0000FFFF),
                make_op(1'b1, 10'h041, 4'hF, 32'hA5A5A5A5));
      add_entry(make_op(1'b1, 10'h040, 4'h2, 32'h00003300), idle);
      add_entry(make_op(1'b0, 10'h040, 4'hF, '0),
                make_op(1'b0, 10'h041, 4'hF, '0));
      for (int i = 0; i < N_RAND; i++) begin
         add_entry(random_op(), random_op());
      end
   endtask

   // Writes update the selected lanes and reads compare the whole word
   task automatic finish_op(string name, op_t op, word_t dat);
      if (op.we) begin
         for (int l = 0; l < `MEM_NUM_COL; l++) begin
            if (op.sel[l]) begin
               shadow[op.addr][l*`MEM_COL_W +: `MEM_COL_W] =
                  op.data[l*`MEM_COL_W +: `MEM_COL_W];
            end
         end
      end else begin
         check_word(name, dat, shadow[op.addr]);
      end
   endtask

   task automatic apply_entry(op_t a_op, op_t b_op);
      bit a_busy;
      bit b_busy;
      bit first_done;
      bit exp_a_first;
      int cycles;
      a_busy      = a_op.valid;
      b_busy      = b_op.valid;
      first_done  = 1'b0;
      if (a_op.valid && b_op.valid) begin
         exp_a_first = last_b;   // Port not granted last goes first
      end else begin
         exp_a_first = a_op.valid;
      end
      cycles      = 0;
      a_req       = to_req(a_op);
      b_req       = to_req(b_op);
      while (a_busy || b_busy) begin
         @(posedge clk);
         #1;
         cycles++;
         if (!a_busy) check_ack("a_rsp.ack", a_rsp.ack, 1'b0);
         if (!b_busy) check_ack("b_rsp.ack", b_rsp.ack, 1'b0);
         if (!first_done && (a_rsp.ack || b_rsp.ack)) begin
            first_done = 1'b1;
            check_ack("a_rsp.ack", a_rsp.ack, exp_a_first);
            check_ack("b_rsp.ack", b_rsp.ack, !exp_a_first);
            assert (cycles == 2) else begin
               $display("error: t=%0t first ack came %0d cycles after stb, expected 2",
                        $time, cycles);
               abort_run();
            end
         end
         if (a_busy && a_rsp.ack) begin
            finish_op("a_rsp.dat", a_op, a_rsp.dat);
            a_req  = '0;
            a_busy = 1'b0;
         end
         if (b_busy && b_rsp.ack) begin
            finish_op("b_rsp.dat", b_op, b_rsp.dat);
            b_req  = '0;
            b_busy = 1'b0;
         end
      end
      if (a_op.valid && b_op.valid) begin
         last_b = exp_a_first;   // Loser is served last
      end else if (a_op.valid) begin
         last_b = 1'b0;
      end else if (b_op.valid) begin
         last_b = 1'b1;
      end
      // Gap cycle with no late or repeated ack
      @(posedge clk);
      #1;
      check_ack("a_rsp.ack", a_rsp.ack, 1'b0);
      check_ack("b_rsp.ack", b_rsp.ack, 1'b0);
   endtask

   initial begin
      void'($urandom(32'ha6));
      clk    = 1'b0;
      rst_n  = 1'b0;
      a_req  = '0;
      b_req  = '0;
      last_b = 1'b1;   // Port a preferred after reset
      build_table();
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (6) begin   // Quiet bus
         @(posedge clk);
         #1;
         check_ack("a_rsp.ack", a_rsp.ack, 1'b0);
         check_ack("b_rsp.ack", b_rsp.ack, 1'b0);
      end
      for (int i = 0; i < a_ops.size(); i++) begin
         apply_entry(a_ops[i], b_ops[i]);
      end
      $display("PASS: all tests");
      $finish;
   end

   // Watchdog
   initial begin
      #((N_ENTRY * 10 + 50) * PERIOD);
      $display("error: run timed out waiting for ack");
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
//////////////////////////////////////////////////
// Shared types for the memory subsystem
// Wishbone classic structs and arbiter states
//////////////////////////////////////////////////

`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

   // Word address into the RAM
   typedef logic [`MEM_ADDR_W-1:0] addr_t;

   // One full data word, all lanes
   typedef logic [`MEM_NUM_COL*`MEM_COL_W-1:0] word_t;

   // One bit per byte lane
   typedef logic [`MEM_NUM_COL-1:0] sel_t;

   // Master to slave, classic single transfers only
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      addr_t adr;
      sel_t  sel;
      word_t dat;   // Write data
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic  ack;   // One cycle per transfer
      word_t dat;   // Read data, valid with ack
   } wb_rsp_t;

   typedef enum logic [1:0] {arb_idle, arb_port_a, arb_port_b} arb_state_e;

endpackage

`default_nettype wire

//--- source/mem_subsys.sv
//////////////////////////////////////////////////
// Shared memory with two Wishbone classic ports
// Arbiter, RAM controller and byte-enable RAM
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_subsys (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire mem_pkg::wb_req_t  a_req,
   input  wire mem_pkg::wb_req_t  b_req,
   output mem_pkg::wb_rsp_t       a_rsp,
   output mem_pkg::wb_rsp_t       b_rsp
);

   import mem_pkg::*;

   // Shared bus after arbitration
   wb_req_t bus_req;
   wb_rsp_t bus_rsp;

   // RAM side of the controller
   logic    ram_en;
   sel_t    ram_we;
   addr_t   ram_addr;
   word_t   ram_din;
   word_t   ram_dout;

   // Picks one master per cycle
   wb_arbiter arb_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .a_req   (a_req),
      .b_req   (b_req),
      .a_rsp   (a_rsp),
      .b_rsp   (b_rsp),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   // Turns the granted transfer into a RAM access
   wb_ram_slave slave_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .ram_en   (ram_en),
      .ram_we   (ram_we),
      .ram_addr (ram_addr),
      .ram_din  (ram_din),
      .ram_dout (ram_dout)
   );

   // Storage, one column per byte lane
   sp_ram_be #(
      .NUM_COL (`MEM_NUM_COL),
      .COL_W   (`MEM_COL_W),
      .ADDR_W  (`MEM_ADDR_W)
   ) ram_i (
      .clk  (clk),
      .en   (ram_en),
      .we   (ram_we),
      .addr (ram_addr),
      .din  (ram_din),
      .dout (ram_dout)
   );

endmodule

`default_nettype wire

//--- source/sp_ram.sv
//////////////////////////////////////////////////
// Single-port synchronous RAM column, read-first
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sp_ram #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 8
) (
   input  wire                clk,
   input  wire                en,
   input  wire                we,
   input  wire  [ADDR_W-1:0]  addr,
   input  wire  [DATA_W-1:0]  data_in,
   output logic [DATA_W-1:0]  data_out
);

   localparam int DEPTH = 2**ADDR_W;

   // Storage, contents unknown at power up
   logic [DATA_W-1:0] mem [0:DEPTH-1];

   // Old word goes out while the new one goes in
   always_ff @(posedge clk) begin
      if (en) begin
         data_out <= mem[addr];   // Read-first
         if (we) begin
            mem[addr] <= data_in;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/sp_ram_be.sv
//////////////////////////////////////////////////
// RAM with per-byte write enables
// Built from one read-first column per lane
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sp_ram_be #(
   parameter int NUM_COL = 4,
   parameter int COL_W   = 8,
   parameter int ADDR_W  = 10
) (
   input  wire                      clk,
   input  wire                      en,
   input  wire  [NUM_COL-1:0]       we,
   input  wire  [ADDR_W-1:0]        addr,
   input  wire  [NUM_COL*COL_W-1:0] din,
   output wire  [NUM_COL*COL_W-1:0] dout
);

   // All lanes share en and addr so they read together.
   // Only lanes with their we bit set take new data, so a
   // partial write keeps the other bytes of the word.
   for (genvar i = 0; i < NUM_COL; i++) begin : g_lane
      sp_ram #(
         .ADDR_W (ADDR_W),
         .DATA_W (COL_W)
      ) ram_col (
         .clk      (clk),
         .en       (en),
         .we       (we[i]),                     // Lane write enable
         .addr     (addr),
         .data_in  (din[i*COL_W +: COL_W]),
         .data_out (dout[i*COL_W +: COL_W])     // Lane slice of the word
      );
   end

endmodule

`default_nettype wire

//--- source/wb_arbiter.sv
//////////////////////////////////////////////////
// Round-robin arbiter for two Wishbone masters
// Grants the shared bus for a whole cyc
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
   input  wire               clk,
   input  wire               rst_n,
   input  wire mem_pkg::wb_req_t a_req,
   input  wire mem_pkg::wb_req_t b_req,
   output mem_pkg::wb_rsp_t  a_rsp,
   output mem_pkg::wb_rsp_t  b_rsp,
   output mem_pkg::wb_req_t  bus_req,
   input  wire mem_pkg::wb_rsp_t bus_rsp
);

   import mem_pkg::*;

   arb_state_e state_q;
   arb_state_e state_d;
   logic       last_b_q;   // Port b held the bus most recently

   // Next grant
   always_comb begin
      state_d = state_q;
      case (state_q)
         arb_idle: begin
            // On a tie the port that waited longer wins
            if (a_req.cyc && (!b_req.cyc || last_b_q)) begin
               state_d = arb_port_a;
            end else if (b_req.cyc) begin
               state_d = arb_port_b;
            end
         end
         arb_port_a: begin
            if (!a_req.cyc) begin
               state_d = arb_idle;   // Released
            end
         end
         arb_port_b: begin
            if (!b_req.cyc) begin
               state_d = arb_idle;
            end
         end
         default: state_d = arb_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q  <= arb_idle;
         last_b_q <= 1'b1;   // Port a first after reset
      end else begin
         state_q <= state_d;
         if (state_d == arb_port_b) begin
            last_b_q <= 1'b1;
         end else if (state_d == arb_port_a) begin
            last_b_q <= 1'b0;
         end
      end
   end

   // Request and response routing.
   // The port without the grant sees no ack and zero data,
   // and the bus carries no cycle while idle.
   always_comb begin
      bus_req = '0;
      a_rsp   = '0;
      b_rsp   = '0;
      case (state_q)
         arb_port_a: begin
            bus_req = a_req;
            a_rsp   = bus_rsp;
         end
         arb_port_b: begin
            bus_req = b_req;
            b_rsp   = bus_rsp;
         end
         default: begin
            bus_req = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/wb_ram_slave.sv
//////////////////////////////////////////////////
// Wishbone classic slave in front of the RAM
// One RAM access per transfer, ack a cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_ram_slave (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire mem_pkg::wb_req_t  bus_req,
   output mem_pkg::wb_rsp_t       bus_rsp,
   output logic                   ram_en,
   output mem_pkg::sel_t          ram_we,
   output mem_pkg::addr_t         ram_addr,
   output mem_pkg::word_t         ram_din,
   input  wire mem_pkg::word_t    ram_dout
);

   logic start;   // Access issued this cycle
   logic ack_q;

   // The master still holds stb in the ack cycle.
   // Masking with ack_q keeps that cycle from starting
   // a second access to the same address.
   assign start = bus_req.cyc && bus_req.stb && !ack_q;

   // RAM side
   assign ram_en   = start;
   assign ram_we   = (start && bus_req.we) ? bus_req.sel : '0;   // Lanes to write
   assign ram_addr = bus_req.adr;
   assign ram_din  = bus_req.dat;

   // One-cycle ack, lined up with the registered RAM read
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= start;
      end
   end

   assign bus_rsp.ack = ack_q;
   assign bus_rsp.dat = ram_dout;   // Meaningful only for reads

endmodule

`default_nettype wire
